// ==== verilog/wbPkg.sv ====
`default_nettype none

package wbPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;

    localparam word_t EXCEP_VECTOR = 32'hbfc00380;
    localparam int    TIMER_INT_BIT = 30;   // Cause.TI
    localparam int    HW5_IP_BIT = 15;      // Cause.IP7, hw line 5
    localparam word_t STATUS_RESET = 32'h0040_0000;   // only BEV set

    // Status / Cause bit positions
    localparam int    STATUS_IE = 0;
    localparam int    STATUS_EXL = 1;
    localparam int    CAUSE_BD = 31;

    // software-writable fields for MTC0
    localparam word_t STATUS_WMASK = 32'h0000_ff03;   // IM7..IM0, EXL, IE
    localparam word_t CAUSE_WMASK = 32'h0000_0300;    // IP1..IP0

    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        COUNT    = 5'd9,
        COMPARE  = 5'd11,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14
    } cp0Reg_e;

    typedef enum logic [4:0] {
        INT  = 5'h00,
        ADEL = 5'h04,
        ADES = 5'h05,
        SYS  = 5'h08,
        BP   = 5'h09,
        RI   = 5'h0a,
        OV   = 5'h0c
    } excCode_e;

    typedef enum logic [2:0] {
        BYTE_S = 3'd1,
        BYTE_U = 3'd2,
        HALF_S = 3'd3,
        HALF_U = 3'd4,
        WORD   = 3'd5
    } memWidth_e;

    typedef enum logic [1:0] {
        PLAIN = 2'd0,
        LWL   = 2'd1,
        LWR   = 2'd2
    } memCombine_e;

    // exceptions flagged in earlier stages
    typedef struct packed {
        logic sys;
        logic bp;
        logic ov;
        logic adEs;
        logic insAdEl;
        logic dataAdEl;
        logic ri;
    } excFlags_t;

    typedef struct packed {
        word_t       pc;
        logic        delaySlot;
        logic        regWrite;
        regIdx_t     writeReg;
        logic        memToReg;
        word_t       result;      // non-load write value
        word_t       aluResult;   // memory address
        word_t       rtData;      // old rt, MTC0 source
        memWidth_e   memWidth;
        memCombine_e memCombine;
        logic        cp0Wri;
        cp0Reg_e     cp0Sel;
        logic        eret;
        excFlags_t   exc;
    } wbIn_t;

    typedef struct packed {
        logic    wen;
        regIdx_t wnum;
        word_t   wdata;
        word_t   pc;
    } rfWrite_t;

    typedef struct packed {
        logic     take;
        excCode_e code;
        logic     bd;
        word_t    epc;
        logic     badVAddrWr;
        word_t    badVAddr;
    } excepTake_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic    wr;
        cp0Reg_e sel;
        word_t   data;
    } cp0Write_t;

endpackage

`default_nettype wire

// ==== verilog/loadAlign.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadAlign (
    input  wire logic [1:0]         addrLow,
    input  wire wbPkg::memWidth_e   memWidth,
    input  wire wbPkg::memCombine_e memCombine,
    input  wire wbPkg::word_t       readData,
    input  wire wbPkg::word_t       rtData,
    output wbPkg::word_t            loadData
);
    import wbPkg::*;

    logic [7:0]  selByte;
    logic [15:0] selHalf;
    word_t       extData;
    word_t       lwlData;
    word_t       lwrData;

    assign selByte = readData[8*addrLow +: 8];
    assign selHalf = addrLow[1] ? readData[31:16] : readData[15:0];   // aligned halves only

    always_comb begin
        case (memWidth)
            BYTE_S: extData = {{24{selByte[7]}}, selByte};
            BYTE_U: extData = {24'b0, selByte};
            HALF_S: extData = {{16{selHalf[15]}}, selHalf};
            HALF_U: extData = {16'b0, selHalf};
            default: extData = readData;   // WORD
        endcase
    end

    // LWL fills from the top, rt keeps the low bytes
    always_comb begin
        case (addrLow)
            2'd0: lwlData = {readData[7:0], rtData[23:0]};
            2'd1: lwlData = {readData[15:0], rtData[15:0]};
            2'd2: lwlData = {readData[23:0], rtData[7:0]};
            default: lwlData = readData;
        endcase
    end

    // LWR fills from the bottom, rt keeps the high bytes
    always_comb begin
        case (addrLow)
            2'd0: lwrData = readData;
            2'd1: lwrData = {rtData[31:24], readData[31:8]};
            2'd2: lwrData = {rtData[31:16], readData[31:16]};
            default: lwrData = {rtData[31:8], readData[31:24]};
        endcase
    end

    always_comb begin
        case (memCombine)
            LWL: loadData = lwlData;
            LWR: loadData = lwrData;
            default: loadData = extData;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cp0Regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0Regs (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire wbPkg::excepTake_t excepTake,
    input  wire wbPkg::cp0Write_t  cp0Write,
    input  wire logic              eretDone,
    input  wire wbPkg::cp0Reg_e    cp0ReadSel,
    output wbPkg::word_t           cp0ReadData,
    output wbPkg::word_t           epc,
    output logic                   intReq
);
    import wbPkg::*;

    word_t badVAddr;
    word_t count;
    word_t compare;
    word_t status;
    word_t cause;
    word_t epcReg;
    logic  countPhase;   // count ticks on every other edge
    logic  timerMatch;

    assign timerMatch = (count == compare);

    // control state: timer, Status, Cause
    always_ff @(posedge clk) begin
        if (!resetn) begin
            countPhase <= 1'b0;
            count <= '0;
            compare <= '0;
            status <= STATUS_RESET;
            cause <= '0;
        end else begin
            countPhase <= ~countPhase;
            if (countPhase) begin
                count <= count + 32'd1;
            end

            // timer pending, also routed to hw line 5
            cause[TIMER_INT_BIT] <= timerMatch;
            cause[HW5_IP_BIT] <= timerMatch;

            if (excepTake.take) begin
                status[STATUS_EXL] <= 1'b1;
                cause[6:2] <= excepTake.code;
                if (!status[STATUS_EXL]) begin   // nested exception keeps BD
                    cause[CAUSE_BD] <= excepTake.bd;
                end
            end else if (cp0Write.wr) begin
                case (cp0Write.sel)
                    COUNT: count <= cp0Write.data;
                    COMPARE: begin
                        compare <= cp0Write.data;
                        cause[TIMER_INT_BIT] <= 1'b0;   // ack timer
                    end
                    STATUS: status <= (status & ~STATUS_WMASK) | (cp0Write.data & STATUS_WMASK);
                    CAUSE: cause <= (cause & ~CAUSE_WMASK) | (cp0Write.data & CAUSE_WMASK);
                    default: ;
                endcase
            end

            if (eretDone) begin
                status[STATUS_EXL] <= 1'b0;
            end
        end
    end

    // address registers
    always_ff @(posedge clk) begin
        if (excepTake.take) begin
            if (excepTake.badVAddrWr) begin
                badVAddr <= excepTake.badVAddr;
            end
            if (!status[STATUS_EXL]) begin
                epcReg <= excepTake.epc;
            end
        end else if (cp0Write.wr && cp0Write.sel == EPC) begin
            epcReg <= cp0Write.data;
        end
    end

    assign epc = epcReg;

    assign intReq = status[STATUS_IE] && !status[STATUS_EXL] &&
                    (|(status[15:8] & cause[15:8]));

    // MFC0 read port
    always_comb begin
        case (cp0ReadSel)
            BADVADDR: cp0ReadData = badVAddr;
            COUNT: cp0ReadData = count;
            COMPARE: cp0ReadData = compare;
            STATUS: cp0ReadData = status;
            CAUSE: cp0ReadData = cause;
            EPC: cp0ReadData = epcReg;
            default: cp0ReadData = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/commitControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module commitControl (
    input  wire logic          wbValid,
    input  wire wbPkg::wbIn_t  wbIn,
    input  wire wbPkg::word_t  loadData,
    input  wire logic          intReq,
    input  wire wbPkg::word_t  epc,
    output wbPkg::rfWrite_t    rfWrite,
    output wbPkg::redirect_t   redirect,
    output wbPkg::excepTake_t  excepTake,
    output wbPkg::cp0Write_t   cp0Write,
    output logic               eretDone
);
    import wbPkg::*;

    logic take;
    logic commit;   // retires normally

    assign take = wbValid && (intReq || (|wbIn.exc));
    assign commit = wbValid && !take;

    always_comb begin
        excepTake = '0;
        excepTake.take = take;
        excepTake.bd = wbIn.delaySlot;
        excepTake.epc = wbIn.delaySlot ? (wbIn.pc - 32'd4) : wbIn.pc;

        // priority order
        if (intReq) begin
            excepTake.code = INT;
        end else if (wbIn.exc.insAdEl) begin
            excepTake.code = ADEL;
            excepTake.badVAddrWr = take;
            excepTake.badVAddr = wbIn.pc;
        end else if (wbIn.exc.ri) begin
            excepTake.code = RI;
        end else if (wbIn.exc.ov) begin
            excepTake.code = OV;
        end else if (wbIn.exc.bp) begin
            excepTake.code = BP;
        end else if (wbIn.exc.sys) begin
            excepTake.code = SYS;
        end else if (wbIn.exc.adEs) begin
            excepTake.code = ADES;
            excepTake.badVAddrWr = take;
            excepTake.badVAddr = wbIn.aluResult;
        end else begin
            excepTake.code = ADEL;   // data AdEL
            excepTake.badVAddrWr = take && wbIn.exc.dataAdEl;
            excepTake.badVAddr = wbIn.aluResult;
        end
    end

    assign rfWrite.wen = commit && wbIn.regWrite;
    assign rfWrite.wnum = wbIn.writeReg;
    assign rfWrite.wdata = wbIn.memToReg ? loadData : wbIn.result;
    assign rfWrite.pc = wbIn.pc;

    assign cp0Write.wr = commit && wbIn.cp0Wri;
    assign cp0Write.sel = wbIn.cp0Sel;
    assign cp0Write.data = wbIn.rtData;

    assign eretDone = commit && wbIn.eret;

    assign redirect.valid = take || eretDone;
    assign redirect.target = take ? EXCEP_VECTOR : epc;

endmodule

`default_nettype wire

// ==== verilog/writebackStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writebackStage (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire logic           memValid,
    input  wire wbPkg::wbIn_t   memIn,
    input  wire wbPkg::word_t   memReadData,
    input  wire wbPkg::cp0Reg_e cp0ReadSel,
    output wbPkg::word_t        cp0ReadData,
    output wbPkg::rfWrite_t     rfWrite,
    output wbPkg::redirect_t    redirect
);
    import wbPkg::*;

    logic       wbValid;
    wbIn_t      wbIn;
    word_t      wbReadData;
    word_t      loadData;
    word_t      epc;
    logic       intReq;
    excepTake_t excepTake;
    cp0Write_t  cp0Write;
    logic       eretDone;

    // ME->WB register, stage always accepts
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= memValid && !excepTake.take;   // kill the younger instruction
        end
    end

    always_ff @(posedge clk) begin
        if (memValid) begin
            wbIn <= memIn;
            wbReadData <= memReadData;
        end
    end

    loadAlign i_loadAlign (
        .addrLow    (wbIn.aluResult[1:0]),
        .memWidth   (wbIn.memWidth),
        .memCombine (wbIn.memCombine),
        .readData   (wbReadData),
        .rtData     (wbIn.rtData),
        .loadData   (loadData)
    );

    cp0Regs i_cp0Regs (
        .clk         (clk),
        .resetn      (resetn),
        .excepTake   (excepTake),
        .cp0Write    (cp0Write),
        .eretDone    (eretDone),
        .cp0ReadSel  (cp0ReadSel),
        .cp0ReadData (cp0ReadData),
        .epc         (epc),
        .intReq      (intReq)
    );

    commitControl i_commitControl (
        .wbValid   (wbValid),
        .wbIn      (wbIn),
        .loadData  (loadData),
        .intReq    (intReq),
        .epc       (epc),
        .rfWrite   (rfWrite),
        .redirect  (redirect),
        .excepTake (excepTake),
        .cp0Write  (cp0Write),
        .eretDone  (eretDone)
    );

endmodule

`default_nettype wire

// ==== dv/tbWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbWriteback;
    import wbPkg::*;

    logic      clk;
    logic      resetn;
    logic      memValid;
    wbIn_t     memIn;
    word_t     memReadData;
    cp0Reg_e   cp0ReadSel;
    word_t     cp0ReadData;
    rfWrite_t  rfWrite;
    redirect_t redirect;

    int mismatchCount;
    int otherErrCount;

    writebackStage i_dut (
        .clk         (clk),
        .resetn      (resetn),
        .memValid    (memValid),
        .memIn       (memIn),
        .memReadData (memReadData),
        .cp0ReadSel  (cp0ReadSel),
        .cp0ReadData (cp0ReadData),
        .rfWrite     (rfWrite),
        .redirect    (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t randWord();
        return $urandom;
    endfunction

    // harmless instruction with no write, CP0 access or exception
    function automatic wbIn_t baseInstr();
        wbIn_t ins;
        word_t r;
        ins = '0;
        r = randWord();
        ins.pc = randWord() & 32'hffff_fffc;
        ins.writeReg = r[4:0];
        ins.result = randWord();
        ins.aluResult = randWord();
        ins.rtData = randWord();
        ins.memWidth = WORD;
        ins.memCombine = PLAIN;
        ins.cp0Sel = STATUS;
        return ins;
    endfunction

    function automatic rfWrite_t retireOf(input wbIn_t ins, input logic wen, input word_t data);
        rfWrite_t rf;
        rf.wen = wen;
        rf.wnum = ins.writeReg;
        rf.wdata = data;
        rf.pc = ins.pc;
        return rf;
    endfunction

    function automatic redirect_t redirectTo(input logic valid, input word_t target);
        redirect_t rd;
        rd.valid = valid;
        rd.target = target;
        return rd;
    endfunction

    // shift the addressed item down and extend it
    function automatic word_t extendLoad(input memWidth_e w, input logic [1:0] a, input word_t d);
        word_t sh;
        sh = d >> (8 * a);
        case (w)
            BYTE_S: return {{24{sh[7]}}, sh[7:0]};
            BYTE_U: return {24'd0, sh[7:0]};
            HALF_S: return {{16{sh[15]}}, sh[15:0]};
            HALF_U: return {16'd0, sh[15:0]};
            default: return d;
        endcase
    endfunction

    function automatic word_t mergeLoad(input memCombine_e m, input logic [1:0] a,
                                        input word_t d, input word_t rt);
        int n;
        n = int'(a);
        if (m == LWL) begin
            return (d << (8 * (3 - n))) | (rt & (32'hffff_ffff >> (8 * (n + 1))));
        end
        return (d >> (8 * n)) | (rt & ~(32'hffff_ffff >> (8 * n)));   // LWR
    endfunction

    function automatic excCode_e excCodeFor(input excFlags_t f);
        if (f.insAdEl) return ADEL;
        if (f.ri) return RI;
        if (f.ov) return OV;
        if (f.bp) return BP;
        if (f.sys) return SYS;
        if (f.adEs) return ADES;
        return ADEL;
    endfunction

    task automatic checkRfWrite(input string name, input rfWrite_t exp, input rfWrite_t act);
        string expStr;
        string actStr;
        if (act.wen !== exp.wen || act.wnum !== exp.wnum || act.pc !== exp.pc ||
            (exp.wen && act.wdata !== exp.wdata)) begin
            mismatchCount++;
            expStr = $sformatf("wen=%b wnum=%0d wdata=%h pc=%h", exp.wen, exp.wnum, exp.wdata,
                               exp.pc);
            actStr = $sformatf("wen=%b wnum=%0d wdata=%h pc=%h", act.wen, act.wnum, act.wdata,
                               act.pc);
            $display("MISMATCH time=%0t %s expected %s actual %s", $time, name, expStr, actStr);
        end
    endtask

    task automatic checkRedirect(input string name, input redirect_t exp, input redirect_t act);
        if (act.valid !== exp.valid || (exp.valid && act.target !== exp.target)) begin
            mismatchCount++;
            $display("MISMATCH time=%0t %s expected valid=%b target=%h actual valid=%b target=%h",
                     $time, name, exp.valid, exp.target, act.valid, act.target);
        end
    endtask

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            mismatchCount++;
            $display("MISMATCH time=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // drives one instruction for one cycle and returns at the following negedge
    task automatic sendInstr(input wbIn_t ins, input word_t readData);
        @(negedge clk);
        memIn = ins;
        memReadData = readData;
        memValid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        memValid = 1'b0;
    endtask

    task automatic settleCommit();   // CP0 updates on the next edge
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic readCp0(input cp0Reg_e sel, output word_t val);
        cp0ReadSel = sel;
        #1;
        val = cp0ReadData;
    endtask

    task automatic mtc0(input cp0Reg_e sel, input word_t data);
        wbIn_t ins;
        ins = baseInstr();
        ins.cp0Wri = 1'b1;
        ins.cp0Sel = sel;
        ins.rtData = data;
        sendInstr(ins, randWord());
        checkRedirect("mtc0 redirect", redirectTo(1'b0, '0), redirect);
        settleCommit();
    endtask

    task automatic loadExtension();
        wbIn_t ins;
        word_t rd;
        memWidth_e w;
        for (int wi = 1; wi <= 5; wi++) begin
            for (int a = 0; a < 4; a++) begin
                w = memWidth_e'(wi);
                if ((w == HALF_S || w == HALF_U) && a[0]) continue;
                if (w == WORD && a != 0) continue;
                ins = baseInstr();
                ins.regWrite = 1'b1;
                ins.memToReg = 1'b1;
                ins.memWidth = w;
                ins.aluResult = {ins.aluResult[31:2], a[1:0]};
                rd = randWord();
                sendInstr(ins, rd);
                checkRfWrite("load rfWrite", retireOf(ins, 1'b1, extendLoad(w, a[1:0], rd)),
                             rfWrite);
                checkRedirect("load redirect", redirectTo(1'b0, '0), redirect);
            end
        end
        // non-load write takes the earlier result
        ins = baseInstr();
        ins.regWrite = 1'b1;
        sendInstr(ins, randWord());
        checkRfWrite("alu rfWrite", retireOf(ins, 1'b1, ins.result), rfWrite);
    endtask

    task automatic loadMerge();
        wbIn_t ins;
        word_t rd;
        memCombine_e m;
        for (int mi = 1; mi <= 2; mi++) begin
            for (int a = 0; a < 4; a++) begin
                m = memCombine_e'(mi);
                ins = baseInstr();
                ins.regWrite = 1'b1;
                ins.memToReg = 1'b1;
                ins.memCombine = m;
                ins.aluResult = {ins.aluResult[31:2], a[1:0]};
                rd = randWord();
                sendInstr(ins, rd);
                checkRfWrite("lwl/lwr rfWrite",
                             retireOf(ins, 1'b1, mergeLoad(m, a[1:0], rd, ins.rtData)), rfWrite);
            end
        end
    endtask

    task automatic exceptionCommit();
        wbIn_t ins;
        word_t r;
        word_t val;
        word_t expEpc;
        word_t expBadV;
        logic expBd;
        logic expExl;
        logic badVKnown;
        logic [6:0] flagBits;
        excCode_e code;
        expExl = 1'b0;   // out of reset
        badVKnown = 1'b0;
        expEpc = '0;
        expBadV = '0;
        expBd = 1'b0;
        for (int i = 0; i < 6; i++) begin
            ins = baseInstr();
            ins.regWrite = 1'b1;
            r = randWord();
            ins.delaySlot = (i == 0) ? 1'b1 : r[20];   // first one records a delay slot EPC
            flagBits = r[6:0] & r[13:7];   // sparse flag sets
            if (flagBits == 7'd0) flagBits = 7'b0000010;
            ins.exc = flagBits;
            sendInstr(ins, randWord());
            checkRfWrite("exc rfWrite", retireOf(ins, 1'b0, ins.result), rfWrite);
            checkRedirect("exc redirect", redirectTo(1'b1, EXCEP_VECTOR), redirect);
            code = excCodeFor(ins.exc);
            if (!expExl) begin   // only the first one records EPC and BD
                expEpc = ins.delaySlot ? ins.pc - 32'd4 : ins.pc;
                expBd = ins.delaySlot;
            end
            expExl = 1'b1;
            if (ins.exc.insAdEl) begin
                expBadV = ins.pc;
                badVKnown = 1'b1;
            end else if (code == ADES || code == ADEL) begin
                expBadV = ins.aluResult;
                badVKnown = 1'b1;
            end
            settleCommit();
            readCp0(CAUSE, val);
            checkWord("Cause.ExcCode", {27'd0, code}, {27'd0, val[6:2]});
            checkWord("Cause.BD", {31'd0, expBd}, {31'd0, val[31]});
            readCp0(EPC, val);
            checkWord("EPC", expEpc, val);
            readCp0(STATUS, val);
            checkWord("Status.EXL", {31'd0, expExl}, {31'd0, val[1]});
            if (badVKnown) begin
                readCp0(BADVADDR, val);
                checkWord("BadVAddr", expBadV, val);
            end
        end
    endtask

    task automatic flushYounger();
        wbIn_t bad;
        wbIn_t next;
        bad = baseInstr();
        bad.exc.sys = 1'b1;
        bad.regWrite = 1'b1;
        next = baseInstr();
        next.regWrite = 1'b1;
        @(negedge clk);
        memIn = bad;
        memValid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        checkRedirect("flush exc redirect", redirectTo(1'b1, EXCEP_VECTOR), redirect);
        memIn = next;   // back to back with memValid held high
        @(posedge clk);
        @(negedge clk);
        memValid = 1'b0;
        checkRfWrite("flushed rfWrite", retireOf(next, 1'b0, next.result), rfWrite);
        checkRedirect("flushed redirect", redirectTo(1'b0, '0), redirect);
        settleCommit();
    endtask

    task automatic mtc0ThenEret();
        wbIn_t ins;
        word_t stData;
        word_t caData;
        word_t epcData;
        word_t caOld;
        word_t val;
        stData = (randWord() & ~32'h3) | 32'h2;   // IE clear and EXL set
        caData = randWord() | 32'h0000_0300;
        epcData = randWord();
        mtc0(STATUS, stData);
        readCp0(STATUS, val);
        checkWord("Status", (STATUS_RESET & ~32'h0000_ff03) | (stData & 32'h0000_ff03), val);
        readCp0(CAUSE, caOld);
        mtc0(CAUSE, caData);
        readCp0(CAUSE, val);
        checkWord("Cause", (caOld & ~32'h0000_0300) | (caData & 32'h0000_0300), val);
        mtc0(EPC, epcData);
        readCp0(EPC, val);
        checkWord("EPC", epcData, val);
        ins = baseInstr();
        ins.eret = 1'b1;
        sendInstr(ins, randWord());
        checkRedirect("eret redirect", redirectTo(1'b1, epcData), redirect);
        checkRfWrite("eret rfWrite", retireOf(ins, 1'b0, ins.result), rfWrite);
        settleCommit();
        readCp0(STATUS, val);
        checkWord("Status.EXL after eret", 32'd0, {31'd0, val[1]});
    endtask

    task automatic timerInterrupt();
        wbIn_t ins;
        word_t cnt;
        word_t val;
        int cycles;
        logic hit;
        mtc0(STATUS, 32'h0000_8001);   // IE and IM7 set with EXL clear
        readCp0(COUNT, cnt);
        mtc0(COMPARE, cnt + 32'd20);
        ins = baseInstr();
        @(negedge clk);
        memIn = ins;
        memValid = 1'b1;
        cycles = 0;
        hit = 1'b0;
        while (!hit && cycles < 200) begin
            @(negedge clk);
            cycles++;
            hit = redirect.valid;
        end
        memValid = 1'b0;
        if (!hit) begin
            otherErrCount++;
            $display("timer interrupt was not taken within 200 cycles, time %0t", $time);
        end else begin
            checkRedirect("timer redirect", redirectTo(1'b1, EXCEP_VECTOR), redirect);
            readCp0(CAUSE, val);
            checkWord("Cause.TI", 32'd1, {31'd0, val[30]});
            settleCommit();
            readCp0(CAUSE, val);
            checkWord("Cause.ExcCode", {27'd0, INT}, {27'd0, val[6:2]});
            checkWord("Cause.BD", 32'd0, {31'd0, val[31]});
            readCp0(EPC, val);
            checkWord("EPC after interrupt", ins.pc, val);
        end
    endtask

    initial begin
        void'($urandom(32'h6cbc));
        mismatchCount = 0;
        otherErrCount = 0;
        resetn = 1'b0;
        memValid = 1'b0;
        memIn = '0;
        memReadData = '0;
        cp0ReadSel = STATUS;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        loadExtension();
        loadMerge();
        exceptionCommit();
        flushYounger();
        mtc0ThenEret();
        timerInterrupt();

        $display("error counts: mismatches=%0d other=%0d", mismatchCount, otherErrCount);
        if (mismatchCount == 0 && otherErrCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/wbPkg.sv
verilog/loadAlign.sv
verilog/cp0Regs.sv
verilog/commitControl.sv
verilog/writebackStage.sv
dv/tbWriteback.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the writeback testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -j 0 \
    -f verilog.f --top-module tbWriteback -o simWriteback

./obj_dir/simWriteback | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi
